// File: build.f
+incdir+logic
logic/gfxPkg.sv
logic/cmdBuffer.sv
logic/cmdParser.sv
logic/attribState.sv
logic/gfxFrontEnd.sv
verification/gfxFrontEnd_checker.sv
verification/gfxFrontEnd_tb.sv

// File: run.sh
#!/bin/sh
# build and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert \
    --top-module gfxFrontEnd_tb \
    -f build.f \
    --Mdir obj_dir -o simv

# let bound assertions keep counting so the testbench can report them
./obj_dir/simv +verilator+error+limit+1000

// File: verification/gfxFrontEnd_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "gfx_config.svh"

module gfxFrontEnd_tb import gfxPkg::*; ();

    localparam logic [31:0] Seed   = 32'hfcba8b2f;
    localparam logic [31:0] OneF   = 32'h3f800000;   // 1.0f
    localparam logic [31:0] ZeroF  = 32'h00000000;

    logic                       BRAM_clk;
    logic                       rstN;
    hostPortS                   host;
    logic [`GFX_DATA_WIDTH-1:0] rdata;
    logic                       start;
    logic                       busy;
    logic                       done;
    logic                       error;
    vertexS                     vertexOut;
    logic                       vertexValid;
    logic                       vertexReady;
    matrixRowS                  rowOut;
    logic                       rowValid;

    logic [31:0] shadow [0:`GFX_BUF_DEPTH-1];   // expected buffer contents
    logic [31:0] prog [$];                      // program under construction
    vertexS      expVerts [$];
    matrixRowS   expRows [$];
    logic        expError;
    logic [31:0] refR;
    logic [31:0] refG;
    logic [31:0] refB;
    matrixSelE   refMode;
    logic [31:0] dataRng;
    logic [31:0] stallRng;
    int          readyMode;   // 0 always ready, 1 random stalls

    gfxFrontEnd u_gfxFrontEnd (
        .BRAM_clk    (BRAM_clk),
        .rstN        (rstN),
        .host        (host),
        .rdata       (rdata),
        .start       (start),
        .busy        (busy),
        .done        (done),
        .error       (error),
        .vertexOut   (vertexOut),
        .vertexValid (vertexValid),
        .vertexReady (vertexReady),
        .rowOut      (rowOut),
        .rowValid    (rowValid)
    );

    bind gfxFrontEnd gfxFrontEnd_checker u_checker (
        .BRAM_clk    (BRAM_clk),
        .rstN        (rstN),
        .beat        (beat),
        .beatValid   (beatValid),
        .beatReady   (beatReady),
        .vertexOut   (vertexOut),
        .vertexValid (vertexValid),
        .vertexReady (vertexReady),
        .busy        (busy),
        .done        (done)
    );

    always #2 BRAM_clk = ~BRAM_clk;

    ////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v ^= v << 13;
        v ^= v >> 17;
        v ^= v << 5;
        return v;
    endfunction

    function automatic logic [31:0] nextData();
        dataRng = xorshift(dataRng);
        return dataRng;
    endfunction

    function automatic logic [31:0] mergeLanes(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] wen);
        logic [31:0] res;
        res = old;
        for (int l = 0; l < 4; l++) begin
            if (wen[l]) res[8*l +: 8] = data[8*l +: 8];
        end
        return res;
    endfunction

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic checkVertex(input vertexS exp, input vertexS got);
        if (got !== exp) begin
            failRun($sformatf("Error at %0t ns: vertexOut expected %h, got %h",
                              $time, exp, got));
        end
    endtask

    task automatic checkRow(input matrixRowS exp, input matrixRowS got);
        if (got !== exp) begin
            failRun($sformatf("Error at %0t ns: rowOut expected %h, got %h",
                              $time, exp, got));
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            failRun($sformatf("Error at %0t ns: %s expected %b, got %b",
                              $time, name, exp, got));
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            failRun($sformatf("Error at %0t ns: %s expected %h, got %h",
                              $time, name, exp, got));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // reference model, walks the shadow copy of the buffer
    ////////////////////////////////////////////////////////////////////////

    function automatic void buildExpected();
        int          ptr;
        int          count;
        int          need;
        logic [31:0] w;
        bit          running;
        vertexS      v;
        matrixRowS   row;
        ptr = 0;
        running = 1'b1;
        expError = 1'b0;
        while (running) begin
            if (ptr >= `GFX_BUF_DEPTH) begin
                expError = 1'b1;
                running = 1'b0;
            end else begin
                w = shadow[ptr];
                case (w[7:0])
                    cmdVertex, cmdColor: need = 3;
                    cmdMultMatrix:       need = 16;
                    cmdMatrixMode:       need = 0;
                    default:             need = -1;   // unknown opcode
                endcase
                count = w[31] ? int'(w[15:8]) : 0;
                if (w == 32'd0) begin
                    running = 1'b0;   // end of stream
                end else if (need < 0 || count != need || (w[31] && need == 0) ||
                             ptr + count >= `GFX_BUF_DEPTH) begin
                    expError = 1'b1;
                    running = 1'b0;
                end else begin
                    case (w[7:0])
                        cmdMatrixMode: begin
                            refMode = (w[15:8] == 8'd1) ? selProjection : selModelview;
                        end
                        cmdColor: begin
                            refR = shadow[ptr + 1];
                            refG = shadow[ptr + 2];
                            refB = shadow[ptr + 3];
                        end
                        cmdVertex: begin
                            v.x = shadow[ptr + 1];
                            v.y = shadow[ptr + 2];
                            v.z = shadow[ptr + 3];
                            v.r = refR;
                            v.g = refG;
                            v.b = refB;
                            expVerts.push_back(v);
                        end
                        default: begin   // multiply matrix, one row per four operands
                            for (int k = 0; k < 4; k++) begin
                                row.sel = refMode;
                                row.row = 2'(k);
                                for (int j = 0; j < 4; j++) begin
                                    row.words[j] = shadow[ptr + 1 + 4*k + j];
                                end
                                expRows.push_back(row);
                            end
                        end
                    endcase
                    ptr = ptr + count + 1;
                end
            end
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // program building and host port
    ////////////////////////////////////////////////////////////////////////

    function automatic void addLong(input cmdOpcodeE op, input logic [7:0] count);
        prog.push_back({1'b1, 15'd0, count, 8'(op)});
    endfunction

    function automatic void addMode(input matrixSelE sel);
        prog.push_back({1'b0, 15'd0, 7'd0, sel, 8'(cmdMatrixMode)});
    endfunction

    function automatic void addRandomOps(input int n);
        for (int i = 0; i < n; i++) begin
            prog.push_back(nextData());
        end
    endfunction

    function automatic void addColor(input logic [31:0] r, input logic [31:0] g,
                                     input logic [31:0] b);
        addLong(cmdColor, 8'd3);
        prog.push_back(r);
        prog.push_back(g);
        prog.push_back(b);
    endfunction

    task automatic hostWrite(input logic [9:0] addr, input logic [31:0] data,
                             input logic [3:0] wen, input bit stored);
        @(negedge BRAM_clk);
        host.en    = 1'b1;
        host.wen   = wen;
        host.addr  = addr;
        host.wdata = data;
        if (stored) shadow[addr] = mergeLanes(shadow[addr], data, wen);
        @(negedge BRAM_clk);
        host = '0;
    endtask

    task automatic hostCheck(input logic [9:0] addr);
        @(negedge BRAM_clk);
        host.en   = 1'b0;
        host.addr = addr;
        @(posedge BRAM_clk);
        checkWord("rdata", shadow[addr], rdata);
    endtask

    task automatic loadProgram();
        foreach (prog[i]) begin
            hostWrite(10'(i), prog[i], 4'hF, 1'b1);
        end
        prog.delete();
    endtask

    ////////////////////////////////////////////////////////////////////////
    // runs
    ////////////////////////////////////////////////////////////////////////

    task automatic startRun();
        buildExpected();
        @(negedge BRAM_clk);
        start = 1'b1;
        @(negedge BRAM_clk);
        start = 1'b0;
        checkBit("busy", 1'b1, busy);
        checkBit("error", 1'b0, error);   // cleared by start
    endtask

    task automatic finishRun();
        int cycles;
        cycles = 0;
        do begin
            @(negedge BRAM_clk);
            cycles++;
        end while (done !== 1'b1 && cycles < `GFX_TIMEOUT);
        if (done !== 1'b1) failRun("Timeout: the run never signalled done");
        checkBit("error", expError, error);
        checkBit("busy", 1'b0, busy);
        cycles = 0;
        do begin
            @(negedge BRAM_clk);
            cycles++;
        end while ((expVerts.size() != 0 || expRows.size() != 0) && cycles < `GFX_TIMEOUT);
        if (expVerts.size() != 0 || expRows.size() != 0) begin
            failRun("Timeout: expected vertices or matrix rows never came out");
        end
    endtask

    // compare process, values before the edge
    always @(posedge BRAM_clk) begin
        if (rstN && vertexValid && vertexReady) begin
            if (expVerts.size() == 0) failRun("A vertex came out when none was expected");
            else checkVertex(expVerts.pop_front(), vertexOut);
        end
        if (rstN && rowValid) begin
            if (expRows.size() == 0) failRun("A matrix row came out when none was expected");
            else checkRow(expRows.pop_front(), rowOut);
        end
    end

    // downstream stalls, own random stream
    initial begin
        stallRng = xorshift(Seed);
        vertexReady = 1'b1;
        forever begin
            @(negedge BRAM_clk);
            stallRng = xorshift(stallRng);
            vertexReady = (readyMode == 0) || (stallRng[1:0] != 2'd0);
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] pick;
        logic [31:0] keep;
        logic [9:0]  addr;
        BRAM_clk  = 1'b0;
        rstN      = 1'b0;
        start     = 1'b0;
        host      = '0;
        readyMode = 0;
        dataRng   = Seed;
        refR      = '0;   // colour and mode after reset
        refG      = '0;
        refB      = '0;
        refMode   = selModelview;
        repeat (2) @(negedge BRAM_clk);
        rstN = 1'b1;
        checkBit("busy", 1'b0, busy);
        checkBit("done", 1'b0, done);
        checkBit("error", 1'b0, error);
        checkBit("vertexValid", 1'b0, vertexValid);
        checkBit("rowValid", 1'b0, rowValid);

        // host writes with partial byte lanes
        for (int n = 0; n < 16; n++) begin
            pick = nextData();
            addr = 10'(512 + pick[8:0]);
            hostWrite(addr, nextData(), 4'hF, 1'b1);
            hostWrite(addr, nextData(), pick[15:12], 1'b1);
            hostCheck(addr);
        end

        // reference stream, projection matrix then three coloured vertices
        addMode(selProjection);
        addLong(cmdMultMatrix, 8'd16);
        addRandomOps(16);
        addColor(OneF, ZeroF, ZeroF);
        addLong(cmdVertex, 8'd3);
        addRandomOps(3);
        addColor(ZeroF, OneF, ZeroF);
        addLong(cmdVertex, 8'd3);
        addRandomOps(3);
        addColor(ZeroF, ZeroF, OneF);
        addLong(cmdVertex, 8'd3);
        addRandomOps(3);
        prog.push_back(32'd0);
        loadProgram();
        startRun();
        finishRun();

        // rows tagged with the selected matrix
        addMode(selModelview);
        addLong(cmdMultMatrix, 8'd16);
        addRandomOps(16);
        addMode(selProjection);
        addLong(cmdMultMatrix, 8'd16);
        addRandomOps(16);
        prog.push_back(32'd0);
        loadProgram();
        startRun();
        finishRun();

        // long random program under stalls, host writes locked out
        for (int n = 0; n < 40; n++) begin
            pick = nextData();
            case (pick[1:0])
                2'd0: addMode(pick[2] ? selProjection : selModelview);
                2'd1: addColor(nextData(), nextData(), nextData());
                2'd2: begin
                    addLong(cmdVertex, 8'd3);
                    addRandomOps(3);
                end
                default: begin
                    addLong(cmdMultMatrix, 8'd16);
                    addRandomOps(16);
                end
            endcase
        end
        prog.push_back(32'd0);
        loadProgram();
        keep = nextData();
        hostWrite(10'd1000, keep, 4'hF, 1'b1);
        readyMode = 1;
        startRun();
        hostWrite(10'd1000, ~keep, 4'hF, 1'b0);   // must be ignored
        finishRun();
        hostCheck(10'd1000);

        // unknown opcode after a good vertex
        addColor(ZeroF, OneF, ZeroF);
        addLong(cmdVertex, 8'd3);
        addRandomOps(3);
        prog.push_back({1'b1, 15'd0, 8'd3, 8'h55});
        addRandomOps(3);
        prog.push_back(32'd0);
        loadProgram();
        startRun();
        finishRun();
        repeat (4) @(negedge BRAM_clk);
        checkBit("error", 1'b1, error);   // held until next start

        // colour with a short operand count
        addLong(cmdColor, 8'd2);
        addRandomOps(2);
        prog.push_back(32'd0);
        loadProgram();
        startRun();
        finishRun();

        // clean run clears the fault
        addColor(OneF, OneF, ZeroF);
        addLong(cmdVertex, 8'd3);
        addRandomOps(3);
        prog.push_back(32'd0);
        loadProgram();
        startRun();
        finishRun();

        repeat (4) @(negedge BRAM_clk);
        if (u_gfxFrontEnd.u_checker.failCount != 0) begin
            failRun("Bound assertions on the front end reported failures");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verification/gfxFrontEnd_checker.sv
`timescale 1ns/1ns
`default_nettype none

module gfxFrontEnd_checker import gfxPkg::*; (
    input logic   BRAM_clk,
    input logic   rstN,
    input opBeatS beat,
    input logic   beatValid,
    input logic   beatReady,
    input vertexS vertexOut,
    input logic   vertexValid,
    input logic   vertexReady,
    input logic   busy,
    input logic   done
);

    int failCount = 0;   // read by the testbench at the end

    ////////////////////////////////////////////////////////////////////////
    // handshakes hold while stalled
    ////////////////////////////////////////////////////////////////////////

    beatHeld: assert property (@(posedge BRAM_clk) disable iff (!rstN)
        beatValid && !beatReady |=> beatValid && $stable(beat))
        else begin
            failCount++;
            $error("operand beat changed or dropped while stalled");
        end

    vertexHeld: assert property (@(posedge BRAM_clk) disable iff (!rstN)
        vertexValid && !vertexReady |=> vertexValid && $stable(vertexOut))
        else begin
            failCount++;
            $error("vertex packet changed or dropped while stalled");
        end

    ////////////////////////////////////////////////////////////////////////
    // status outputs
    ////////////////////////////////////////////////////////////////////////

    donePulse: assert property (@(posedge BRAM_clk) disable iff (!rstN)
        done |=> !done)
        else begin
            failCount++;
            $error("done stayed high for more than one cycle");
        end

    // sync reset, so idle one edge later
    idleAfterReset: assert property (@(posedge BRAM_clk)
        !rstN |=> !busy && !done)
        else begin
            failCount++;
            $error("busy or done high after reset");
        end

endmodule

`default_nettype wire

// File: logic/gfxFrontEnd.sv
`timescale 1ns/1ns
`default_nettype none

`include "gfx_config.svh"

module gfxFrontEnd import gfxPkg::*; (
    input  logic                       BRAM_clk,
    input  logic                       rstN,
    input  hostPortS                   host,
    output logic [`GFX_DATA_WIDTH-1:0] rdata,
    input  logic                       start,
    output logic                       busy,
    output logic                       done,
    output logic                       error,
    output vertexS                     vertexOut,
    output logic                       vertexValid,
    input  logic                       vertexReady,
    output matrixRowS                  rowOut,
    output logic                       rowValid
);

    ////////////////////////////////////////////////////////////////////////
    // internal links
    ////////////////////////////////////////////////////////////////////////

    logic [`GFX_ADDR_BITS-1:0]            cmdAddr;
    logic [`GFX_DATA_WIDTH-1:0]           cmdWord;
    logic [`GFX_ADDR_BITS-1:0]            winAddr;
    logic [3:0][`GFX_DATA_WIDTH-1:0]      winWords;
    opBeatS                               beat;
    logic                                 beatValid;
    logic                                 beatReady;

    cmdBuffer u_cmdBuffer (
        .BRAM_clk (BRAM_clk),
        .host     (host),
        .busy     (busy),        // locks out host writes
        .rdata    (rdata),
        .cmdAddr  (cmdAddr),
        .cmdWord  (cmdWord),
        .winAddr  (winAddr),
        .winWords (winWords)
    );

    cmdParser u_cmdParser (
        .BRAM_clk  (BRAM_clk),
        .rstN      (rstN),
        .start     (start),
        .cmdAddr   (cmdAddr),
        .cmdWord   (cmdWord),
        .winAddr   (winAddr),
        .winWords  (winWords),
        .beat      (beat),
        .beatValid (beatValid),
        .beatReady (beatReady),
        .busy      (busy),
        .done      (done),
        .error     (error)
    );

    attribState u_attribState (
        .BRAM_clk    (BRAM_clk),
        .rstN        (rstN),
        .beat        (beat),
        .beatValid   (beatValid),
        .beatReady   (beatReady),
        .vertexOut   (vertexOut),
        .vertexValid (vertexValid),
        .vertexReady (vertexReady),
        .rowOut      (rowOut),
        .rowValid    (rowValid)
    );

endmodule

`default_nettype wire

// File: logic/attribState.sv
`timescale 1ns/1ns
`default_nettype none

`include "gfx_config.svh"

module attribState import gfxPkg::*; (
    input  logic      BRAM_clk,
    input  logic      rstN,
    input  opBeatS    beat,
    input  logic      beatValid,
    output logic      beatReady,
    output vertexS    vertexOut,
    output logic      vertexValid,
    input  logic      vertexReady,
    output matrixRowS rowOut,
    output logic      rowValid
);

    logic [`GFX_DATA_WIDTH-1:0] colR;
    logic [`GFX_DATA_WIDTH-1:0] colG;
    logic [`GFX_DATA_WIDTH-1:0] colB;
    matrixSelE                  matrixMode;

    logic accept;
    logic isVertex;
    logic isColor;
    logic isMode;
    logic isMatrix;

    assign isVertex = (beat.opcode == cmdVertex);
    assign isColor  = (beat.opcode == cmdColor);
    assign isMode   = (beat.opcode == cmdMatrixMode);
    assign isMatrix = (beat.opcode == cmdMultMatrix);

    // only vertex beats see back-pressure
    assign beatReady = isVertex ? vertexReady : 1'b1;
    assign accept    = beatValid && beatReady;

    ////////////////////////////////////////////////////////////////////////
    // current state registers
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge BRAM_clk) begin
        if (!rstN) begin
            colR       <= '0;
            colG       <= '0;
            colB       <= '0;
            matrixMode <= selModelview;
        end else if (accept) begin
            if (isColor) begin
                colR <= beat.words[0];
                colG <= beat.words[1];
                colB <= beat.words[2];
            end
            if (isMode) begin
                matrixMode <= beat.arg[0] ? selProjection : selModelview;   // 1 = projection
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // vertex and row outputs
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge BRAM_clk) begin
        if (!rstN) begin
            vertexValid <= 1'b0;
            rowValid    <= 1'b0;
        end else begin
            if (accept && isVertex) begin
                vertexValid <= 1'b1;
            end else if (vertexReady) begin
                vertexValid <= 1'b0;   // packet taken downstream
            end
            rowValid <= accept && isMatrix;   // single cycle strobe
        end
    end

    // colour sampled before any update on the same edge
    always_ff @(posedge BRAM_clk) begin
        if (accept && isVertex) begin
            vertexOut.x <= beat.words[0];
            vertexOut.y <= beat.words[1];
            vertexOut.z <= beat.words[2];
            vertexOut.r <= colR;
            vertexOut.g <= colG;
            vertexOut.b <= colB;
        end
        if (accept && isMatrix) begin
            rowOut.sel   <= matrixMode;
            rowOut.row   <= beat.beatIndex;
            rowOut.words <= beat.words;
        end
    end

endmodule

`default_nettype wire

// File: logic/cmdParser.sv
`timescale 1ns/1ns
`default_nettype none

`include "gfx_config.svh"

module cmdParser import gfxPkg::*; (
    input  logic                                BRAM_clk,
    input  logic                                rstN,
    input  logic                                start,
    output logic [`GFX_ADDR_BITS-1:0]           cmdAddr,
    input  logic [`GFX_DATA_WIDTH-1:0]          cmdWord,
    output logic [`GFX_ADDR_BITS-1:0]           winAddr,
    input  logic [3:0][`GFX_DATA_WIDTH-1:0]     winWords,
    output opBeatS                              beat,
    output logic                                beatValid,
    input  logic                                beatReady,
    output logic                                busy,
    output logic                                done,
    output logic                                error
);

    localparam int PtrW  = `GFX_ADDR_BITS + 1;
    localparam int SpanW = PtrW + 1;

    typedef enum logic [1:0] {
        stIdle,
        stFetch,
        stIssue,
        stFinish
    } parserStateE;

    parserStateE     state;
    logic [PtrW-1:0] ptr;       // address of the command word
    logic [PtrW-1:0] winPtr;    // first operand of the current beat
    logic [PtrW-1:0] nextPtr;   // command after the operands
    logic [1:0]      beatIdx;
    logic [1:0]      lastBeat;
    cmdOpcodeE       opcodeR;
    logic [7:0]      argR;
    logic            errorR;

    cmdWordU          cmd;
    logic [7:0]       expCount;
    logic [7:0]       opCount;
    logic             cmdKnown;
    logic             countOk;
    logic             pastEnd;
    logic             spanBad;
    logic             endWord;
    logic [SpanW-1:0] spanEnd;
    logic             accept;

    ////////////////////////////////////////////////////////////////////////
    // command decode
    ////////////////////////////////////////////////////////////////////////

    assign cmd = cmdWord;

    always_comb begin
        expCount = 8'd0;
        cmdKnown = 1'b1;
        case (cmd.shortCmd.opcode)
            cmdVertex, cmdColor: expCount = 8'd3;
            cmdMultMatrix:       expCount = 8'd16;
            cmdMatrixMode:       expCount = 8'd0;
            default:             cmdKnown = 1'b0;
        endcase

        if (cmd.longCmd.hasOperands) begin
            opCount = cmd.longCmd.operandCount;
            countOk = (opCount == expCount) && (expCount != 8'd0);
        end else begin
            opCount = 8'd0;
            countOk = (expCount == 8'd0);   // only matrix mode is short
        end

        spanEnd = SpanW'(ptr) + SpanW'(opCount);   // last operand address
        pastEnd = ptr[PtrW-1];
        spanBad = spanEnd >= SpanW'(`GFX_BUF_DEPTH);
        endWord = (cmdWord == '0);
    end

    assign accept = beatValid && beatReady;

    ////////////////////////////////////////////////////////////////////////
    // control FSM
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge BRAM_clk) begin
        if (!rstN) begin
            state   <= stIdle;
            ptr     <= '0;
            winPtr  <= '0;
            beatIdx <= '0;
            errorR  <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (start) begin
                        state  <= stFetch;
                        ptr    <= '0;
                        errorR <= 1'b0;   // new run, old fault forgotten
                    end
                end
                stFetch: begin
                    if (pastEnd) begin
                        errorR <= 1'b1;
                        state  <= stFinish;
                    end else if (endWord) begin
                        state <= stFinish;
                    end else if (!cmdKnown || !countOk || spanBad) begin
                        errorR <= 1'b1;
                        state  <= stFinish;
                    end else begin
                        state   <= stIssue;
                        beatIdx <= '0;
                        winPtr  <= ptr + 1'b1;
                    end
                end
                stIssue: begin
                    if (accept) begin
                        if (beatIdx == lastBeat) begin
                            state <= stFetch;
                            ptr   <= nextPtr;
                        end else begin
                            beatIdx <= beatIdx + 1'b1;
                            winPtr  <= winPtr + PtrW'(4);
                        end
                    end
                end
                default: state <= stIdle;   // finish lasts one cycle
            endcase
        end
    end

    // per-command fields, captured while fetching
    always_ff @(posedge BRAM_clk) begin
        if (state == stFetch) begin
            opcodeR  <= cmdOpcodeE'(cmd.shortCmd.opcode);
            argR     <= cmd.shortCmd.arg;
            lastBeat <= (cmd.shortCmd.opcode == cmdMultMatrix) ? 2'd3 : 2'd0;
            nextPtr  <= ptr + PtrW'(opCount) + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        beat.opcode    = opcodeR;
        beat.arg       = argR;
        beat.beatIndex = beatIdx;
        for (int i = 0; i < 3; i++) begin
            beat.words[i] = (opcodeR == cmdMatrixMode) ? '0 : winWords[i];
        end
        beat.words[3] = (opcodeR == cmdMultMatrix) ? winWords[3] : '0;
    end

    assign cmdAddr   = ptr[`GFX_ADDR_BITS-1:0];
    assign winAddr   = winPtr[`GFX_ADDR_BITS-1:0];
    assign beatValid = (state == stIssue);
    assign busy      = (state == stFetch) || (state == stIssue);
    assign done      = (state == stFinish);
    assign error     = errorR;

endmodule

`default_nettype wire

// File: logic/cmdBuffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "gfx_config.svh"

module cmdBuffer import gfxPkg::*; (
    input  logic                                BRAM_clk,
    input  hostPortS                            host,
    input  logic                                busy,
    output logic [`GFX_DATA_WIDTH-1:0]          rdata,
    input  logic [`GFX_ADDR_BITS-1:0]           cmdAddr,
    output logic [`GFX_DATA_WIDTH-1:0]          cmdWord,
    input  logic [`GFX_ADDR_BITS-1:0]           winAddr,
    output logic [3:0][`GFX_DATA_WIDTH-1:0]     winWords
);

    localparam int AddrW = `GFX_ADDR_BITS + 1;   // one spare bit to see the end
    localparam int Lanes = `GFX_DATA_WIDTH / 8;

    logic [`GFX_DATA_WIDTH-1:0] mem [0:`GFX_BUF_DEPTH-1];

    // anything at or beyond the depth reads as zero
    function automatic logic [`GFX_DATA_WIDTH-1:0] readAt(input logic [AddrW-1:0] a);
        logic [`GFX_DATA_WIDTH-1:0] word;
        word = '0;
        if (a < AddrW'(`GFX_BUF_DEPTH)) begin
            word = mem[a[`GFX_ADDR_BITS-1:0]];
        end
        return word;
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // host write port, true byte lanes
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge BRAM_clk) begin
        if (host.en && !busy) begin   // program is frozen during a run
            for (int lane = 0; lane < Lanes; lane++) begin
                if (host.wen[lane]) begin
                    mem[host.addr][8*lane +: 8] <= host.wdata[8*lane +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // asynchronous read ports
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        rdata   = readAt({1'b0, host.addr});
        cmdWord = readAt({1'b0, cmdAddr});
    end

    // four-word operand window, upper words may fall off the end
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            winWords[i] = readAt(AddrW'(winAddr) + AddrW'(i));
        end
    end

endmodule

`default_nettype wire

// File: logic/gfxPkg.sv
`default_nettype none

`include "gfx_config.svh"

package gfxPkg;

    ////////////////////////////////////////////////////////////////////////
    // command encoding
    ////////////////////////////////////////////////////////////////////////

    typedef enum logic [7:0] {
        cmdVertex     = 8'h03,  // x, y, z
        cmdColor      = 8'h04,  // r, g, b
        cmdMatrixMode = 8'h10,  // short form, arg selects matrix
        cmdMultMatrix = 8'h11   // 16 operands, row major
    } cmdOpcodeE;

    typedef struct packed {
        logic        hasOperands;
        logic [14:0] reserved;
        logic [7:0]  operandCount;
        logic [7:0]  opcode;
    } longCmdS;

    typedef struct packed {
        logic        hasOperands;
        logic [14:0] reserved;
        logic [7:0]  arg;
        logic [7:0]  opcode;
    } shortCmdS;

    // byte 1 is a count for long commands and an argument for short ones
    typedef union packed {
        longCmdS  longCmd;
        shortCmdS shortCmd;
    } cmdWordU;

    typedef enum logic {
        selModelview  = 1'b0,
        selProjection = 1'b1
    } matrixSelE;

    ////////////////////////////////////////////////////////////////////////
    // streams between the stages
    ////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        cmdOpcodeE                       opcode;
        logic [7:0]                      arg;
        logic [1:0]                      beatIndex;
        logic [3:0][`GFX_DATA_WIDTH-1:0] words;
    } opBeatS;

    typedef struct packed {
        logic [`GFX_DATA_WIDTH-1:0] x;
        logic [`GFX_DATA_WIDTH-1:0] y;
        logic [`GFX_DATA_WIDTH-1:0] z;
        logic [`GFX_DATA_WIDTH-1:0] r;
        logic [`GFX_DATA_WIDTH-1:0] g;
        logic [`GFX_DATA_WIDTH-1:0] b;
    } vertexS;

    typedef struct packed {
        matrixSelE                       sel;
        logic [1:0]                      row;
        logic [3:0][`GFX_DATA_WIDTH-1:0] words;
    } matrixRowS;

    typedef struct packed {
        logic                            en;
        logic [`GFX_DATA_WIDTH/8-1:0]    wen;   // one bit per byte lane
        logic [`GFX_ADDR_BITS-1:0]       addr;
        logic [`GFX_DATA_WIDTH-1:0]      wdata;
    } hostPortS;

endpackage

`default_nettype wire

// File: logic/gfx_config.svh
`ifndef GFX_CONFIG_SVH
`define GFX_CONFIG_SVH

////////////////////////////////////////////////////////////////////////
// command buffer geometry
////////////////////////////////////////////////////////////////////////

`define GFX_BUF_DEPTH 1024   // words in the command RAM
`define GFX_ADDR_BITS 10     // word address width
`define GFX_DATA_WIDTH 32    // command and operand word width

////////////////////////////////////////////////////////////////////////
// simulation limits
////////////////////////////////////////////////////////////////////////

// cycles allowed for any wait on a status output
`define GFX_TIMEOUT 2000

`endif
